// ==== logic/ncpu_mem_pkg.sv ====
// Bus widths, address type, bus request struct and arbiter state enum
`default_nettype none

package ncpu_mem_pkg;

   // Bus geometry
   localparam int BUS_P_DW_BYTES = 3;                 // log2 of bus width in bytes
   localparam int BUS_BYTES      = (1 << BUS_P_DW_BYTES); // 8 byte lanes
   localparam int MEM_AW         = 12;                // Byte address, 4 KiB space
   localparam int MEM_DEPTH      = 512;               // 64-bit words in the bank

   // Widths that carry a meaning
   typedef logic [BUS_BYTES*8-1:0] bus_data_t;        // One bus word
   typedef logic [BUS_BYTES-1:0]   bus_strb_t;        // One strobe per byte lane
   typedef logic [MEM_AW-1:0]      mem_addr_t;        // Byte address

   // Request as seen by the SRAM bank
   typedef struct packed
   {
      logic      we;                                  // Write when set, else read
      mem_addr_t addr;                                // Byte address of the access
      bus_data_t wdata;                               // Payload replicated on all windows
      bus_strb_t wstrb;                               // Lanes to commit on a write
   } bus_req_t;

   // Round-robin memory, port served last
   typedef enum logic
   {
      LAST_P0 = 1'b0,
      LAST_P1 = 1'b1
   } arb_last_t;

endpackage

`default_nettype wire

// ==== logic/align_w.sv ====
// Write aligner that maps a narrow payload onto the byte lanes of the wide bus
`timescale 1ns/10ps
`default_nettype none

module align_w
#(
   parameter int PAYLOAD_P_DW_BYTES = 2                 // log2 of payload size in bytes
)
(
   input  wire logic [(1<<PAYLOAD_P_DW_BYTES)*8-1:0] i_din,   // Narrow payload
   input  wire logic                                 i_we,    // Write access
   input  wire ncpu_mem_pkg::mem_addr_t              i_addr,  // Byte address
   output ncpu_mem_pkg::bus_strb_t                   o_wstrb, // Lanes to write
   output ncpu_mem_pkg::bus_data_t                   o_wdata  // Replicated payload
);
   import ncpu_mem_pkg::*;

   // Window geometry for a payload no wider than the bus
   localparam int PAYLOAD_BYTES = (1 << PAYLOAD_P_DW_BYTES);
   localparam int WIN_NUM       = BUS_BYTES / PAYLOAD_BYTES;          // Windows per word
   localparam int WIN_P_NUM     = BUS_P_DW_BYTES - PAYLOAD_P_DW_BYTES; // Select bits
   localparam int WIN_DW        = PAYLOAD_BYTES * 8;                  // Window width

   logic [WIN_P_NUM-1:0] win_sel;                       // Window picked by the address

   // Bits above the payload offset up to the bus offset
   assign win_sel = i_addr[PAYLOAD_P_DW_BYTES +: WIN_P_NUM];

   always_comb
   begin
      for (int k = 0; k < WIN_NUM; k++)
      begin
         // Same payload in every window while the strobes decide what lands
         o_wdata[k*WIN_DW +: WIN_DW] = i_din;

         // Only the addressed window and only on a write
         o_wstrb[k*PAYLOAD_BYTES +: PAYLOAD_BYTES] =
            {PAYLOAD_BYTES{i_we && (win_sel == WIN_P_NUM'(k))}};
      end
   end

endmodule

`default_nettype wire

// ==== logic/align_r.sv ====
// Read aligner, payload-sized window of the bus read data picked by address
`timescale 1ns/10ps
`default_nettype none

module align_r
#(
   parameter int PAYLOAD_P_DW_BYTES = 2                 // log2 of payload size in bytes
)
(
   input  wire ncpu_mem_pkg::bus_data_t              i_bus_rdata, // Word from the SRAM
   input  wire ncpu_mem_pkg::mem_addr_t              i_addr,      // Byte address
   output logic [(1<<PAYLOAD_P_DW_BYTES)*8-1:0]      o_dout       // Narrow read data
);
   import ncpu_mem_pkg::*;

   // Mirrors the write side geometry
   localparam int PAYLOAD_BYTES = (1 << PAYLOAD_P_DW_BYTES);
   localparam int WIN_NUM       = BUS_BYTES / PAYLOAD_BYTES;
   localparam int WIN_P_NUM     = BUS_P_DW_BYTES - PAYLOAD_P_DW_BYTES;
   localparam int WIN_DW        = PAYLOAD_BYTES * 8;

   logic [WIN_P_NUM-1:0] win_sel;                       // Window index from the address
   logic [WIN_DW-1:0]    win [WIN_NUM];                 // Bus word split into windows

   assign win_sel = i_addr[PAYLOAD_P_DW_BYTES +: WIN_P_NUM]; // Same bits as align_w

   // Little-endian split, window 0 sits on the low lanes
   always_comb
   begin
      for (int k = 0; k < WIN_NUM; k++)
         win[k] = i_bus_rdata[k*WIN_DW +: WIN_DW];
   end

   assign o_dout = win[win_sel];                        // Mux out the addressed window

endmodule

`default_nettype wire

// ==== logic/mem_port.sv ====
// Requester port, holds one request, aligns it onto the bus and returns done with read data
`timescale 1ns/10ps
`default_nettype none

module mem_port
#(
   parameter int PAYLOAD_P_DW_BYTES = 2                 // log2 of payload size in bytes
)
(
   input  wire logic                                 clk,
   input  wire logic                                 i_rst_n,     // Sync, active low
   // Requester side
   input  wire logic                                 i_req,       // One-cycle strobe
   input  wire logic                                 i_we,
   input  wire ncpu_mem_pkg::mem_addr_t              i_addr,
   input  wire logic [(1<<PAYLOAD_P_DW_BYTES)*8-1:0] i_wdata,
   output logic                                      o_busy,      // Request held
   output logic                                      o_done,      // One-cycle completion
   output logic [(1<<PAYLOAD_P_DW_BYTES)*8-1:0]      o_rdata,     // Valid with o_done
   // Arbiter side
   output logic                                      o_pend,      // Wants the bus
   output ncpu_mem_pkg::bus_req_t                    o_bus_req,   // Aligned request
   input  wire logic                                 i_gnt,       // Served this cycle
   input  wire ncpu_mem_pkg::bus_data_t              i_bus_rdata  // Shared SRAM output
);
   import ncpu_mem_pkg::*;

   localparam int PW = (1 << PAYLOAD_P_DW_BYTES) * 8;   // Payload width in bits

   logic          pend_q;                               // Request waiting for a grant
   logic          done_q;                               // Completion pulse
   logic          accept;
   // Held request fields
   logic          we_q;
   mem_addr_t     addr_q;
   logic [PW-1:0] wdata_q;
   // Aligned write side
   bus_data_t     al_wdata;
   bus_strb_t     al_wstrb;

   // Strobes while busy are dropped by design
   assign accept = i_req && !pend_q;

   // Control state
   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         pend_q <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         if (accept)
            pend_q <= 1'b1;
         else if (i_gnt)
            pend_q <= 1'b0;                             // SRAM acts on this edge
         done_q <= pend_q && i_gnt;                     // Pulse one cycle after the grant
      end
   end

   // Payload registers, loaded only on an accepted strobe
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         we_q    <= i_we;
         addr_q  <= i_addr;                             // Stays put through the done cycle
         wdata_q <= i_wdata;
      end
   end

   align_w #(
      .PAYLOAD_P_DW_BYTES (PAYLOAD_P_DW_BYTES)
   ) u_align_w (
      .i_din   (wdata_q),
      .i_we    (we_q),
      .i_addr  (addr_q),
      .o_wstrb (al_wstrb),
      .o_wdata (al_wdata)
   );

   // Request toward the arbiter
   always_comb
   begin
      o_bus_req.we    = we_q;
      o_bus_req.addr  = addr_q;
      o_bus_req.wdata = al_wdata;
      o_bus_req.wstrb = al_wstrb;                       // Zero on reads
   end

   // Registered SRAM word is current in the done cycle
   align_r #(
      .PAYLOAD_P_DW_BYTES (PAYLOAD_P_DW_BYTES)
   ) u_align_r (
      .i_bus_rdata (i_bus_rdata),
      .i_addr      (addr_q),
      .o_dout      (o_rdata)
   );

   assign o_busy = pend_q;
   assign o_pend = pend_q;
   assign o_done = done_q;

endmodule

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
// Round-robin arbiter for two ports and the mux of the winning request onto the SRAM bus
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
(
   input  wire logic                     clk,
   input  wire logic                     i_rst_n,       // Sync, active low
   input  wire logic [1:0]               i_pend,        // Pending level per port
   input  wire ncpu_mem_pkg::bus_req_t   i_req_p0,
   input  wire ncpu_mem_pkg::bus_req_t   i_req_p1,
   output logic [1:0]                    o_gnt,         // One-hot grant, combinational
   output logic                          o_mem_en,      // SRAM access this cycle
   output ncpu_mem_pkg::bus_req_t        o_mem_req      // Request of the winner
);
   import ncpu_mem_pkg::*;

   arb_last_t last_q;                                   // Port served last
   logic [1:0] gnt;

   // Grant rule
   always_comb
   begin
      gnt = 2'b00;
      if (i_pend[0] && i_pend[1])
      begin
         // Contention, the port not served last wins
         if (last_q == LAST_P1)
            gnt = 2'b01;
         else
            gnt = 2'b10;
      end
      else
      begin
         gnt = i_pend;                                  // Single requester or none
      end
   end

   // Round-robin state follows every grant
   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         last_q <= LAST_P1;                             // Port 0 wins first contention
      end
      else
      begin
         if (gnt[0])
            last_q <= LAST_P0;
         else if (gnt[1])
            last_q <= LAST_P1;
      end
   end

   // Winner onto the SRAM bus, default p0 when idle
   always_comb
   begin
      if (gnt[1])
         o_mem_req = i_req_p1;
      else
         o_mem_req = i_req_p0;
   end

   // Granted port drops pending at the edge, so this lasts one cycle
   assign o_mem_en = |gnt;
   assign o_gnt    = gnt;

endmodule

`default_nettype wire

// ==== logic/sram_bank.sv ====
// 512 x 64-bit SRAM bank with byte-strobed writes and registered read
`timescale 1ns/10ps
`default_nettype none

module sram_bank
(
   input  wire logic                     clk,
   input  wire logic                     i_en,          // Access this cycle
   input  wire ncpu_mem_pkg::bus_req_t   i_req,         // Request from the arbiter
   output ncpu_mem_pkg::bus_data_t       o_rdata        // Read word, one cycle later
);
   import ncpu_mem_pkg::*;

   bus_data_t mem [MEM_DEPTH];                          // Storage array

   logic [MEM_AW-BUS_P_DW_BYTES-1:0] word_idx;          // Word address

   // Drop the byte offset within the word
   assign word_idx = i_req.addr[MEM_AW-1:BUS_P_DW_BYTES];

   always_ff @(posedge clk)
   begin
      if (i_en)
      begin
         if (i_req.we)
         begin
            // Commit only the strobed lanes
            for (int b = 0; b < BUS_BYTES; b++)
            begin
               if (i_req.wstrb[b])
                  mem[word_idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
            end
         end
         else
         begin
            o_rdata <= mem[word_idx];                   // Holds until the next read
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/ncpu_mem_top.sv ====
// Memory subsystem top, two requester ports, arbiter and SRAM bank
`timescale 1ns/10ps
`default_nettype none

module ncpu_mem_top
(
   input  wire logic                     clk,
   input  wire logic                     i_rst_n,       // Sync, active low
   // Port 0, 32-bit load/store
   input  wire logic                     i_p0_req,
   input  wire logic                     i_p0_we,
   input  wire ncpu_mem_pkg::mem_addr_t  i_p0_addr,
   input  wire logic [31:0]              i_p0_wdata,
   output logic                          o_p0_busy,
   output logic                          o_p0_done,
   output logic [31:0]                   o_p0_rdata,
   // Port 1, 16-bit peripheral DMA
   input  wire logic                     i_p1_req,
   input  wire logic                     i_p1_we,
   input  wire ncpu_mem_pkg::mem_addr_t  i_p1_addr,
   input  wire logic [15:0]              i_p1_wdata,
   output logic                          o_p1_busy,
   output logic                          o_p1_done,
   output logic [15:0]                   o_p1_rdata
);
   import ncpu_mem_pkg::*;

   logic [1:0] pend;                                    // Bit n from port n
   logic [1:0] gnt;
   bus_req_t   p0_bus_req;
   bus_req_t   p1_bus_req;
   bus_req_t   mem_req;                                 // Arbiter to SRAM
   logic       mem_en;
   bus_data_t  mem_rdata;                               // Shared by both ports

   mem_port #(
      .PAYLOAD_P_DW_BYTES (2)                           // 4-byte payload
   ) u_port0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_req       (i_p0_req),
      .i_we        (i_p0_we),
      .i_addr      (i_p0_addr),
      .i_wdata     (i_p0_wdata),
      .o_busy      (o_p0_busy),
      .o_done      (o_p0_done),
      .o_rdata     (o_p0_rdata),
      .o_pend      (pend[0]),
      .o_bus_req   (p0_bus_req),
      .i_gnt       (gnt[0]),
      .i_bus_rdata (mem_rdata)
   );

   mem_port #(
      .PAYLOAD_P_DW_BYTES (1)                           // 2-byte payload
   ) u_port1 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_req       (i_p1_req),
      .i_we        (i_p1_we),
      .i_addr      (i_p1_addr),
      .i_wdata     (i_p1_wdata),
      .o_busy      (o_p1_busy),
      .o_done      (o_p1_done),
      .o_rdata     (o_p1_rdata),
      .o_pend      (pend[1]),
      .o_bus_req   (p1_bus_req),
      .i_gnt       (gnt[1]),
      .i_bus_rdata (mem_rdata)
   );

   bus_arbiter u_arb (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_pend    (pend),
      .i_req_p0  (p0_bus_req),
      .i_req_p1  (p1_bus_req),
      .o_gnt     (gnt),
      .o_mem_en  (mem_en),
      .o_mem_req (mem_req)
   );

   sram_bank u_sram (
      .clk     (clk),
      .i_en    (mem_en),
      .i_req   (mem_req),
      .o_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== sim/tb_ncpu_mem_top.sv ====
// Directed testbench for the memory subsystem with clock, reset, reference memory, checks and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_ncpu_mem_top;
   import ncpu_mem_pkg::*;

   localparam int CYCLE_LIMIT = 2000;                   // About twice the summed test length

   logic        clk = 1'b0;
   logic        i_rst_n = 1'b0;                        // Held low from time zero
   logic        i_p0_req = 1'b0;
   logic        i_p0_we = 1'b0;
   mem_addr_t   i_p0_addr = '0;
   logic [31:0] i_p0_wdata = '0;
   logic        i_p1_req = 1'b0;
   logic        i_p1_we = 1'b0;
   mem_addr_t   i_p1_addr = '0;
   logic [15:0] i_p1_wdata = '0;
   logic        o_p0_busy;
   logic        o_p0_done;
   logic [31:0] o_p0_rdata;
   logic        o_p1_busy;
   logic        o_p1_done;
   logic [15:0] o_p1_rdata;

   logic [7:0]  ref_mem [1 << MEM_AW];                 // Byte-wide reference memory
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          last_served = 1;                       // Round-robin model starts on port 1
   logic [31:0] rd0;
   logic [15:0] rd1;
   int          lat0;
   int          lat1;

   ncpu_mem_top uut (.*);

   always #5 clk = ~clk;                               // 10 ns period

   // Run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles, errors: %0d",
                  CYCLE_LIMIT, errors);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Narrow access lands little-endian on the aligned window
   task automatic ref_write(input int p, input mem_addr_t a, input logic [31:0] d);
      int nbytes;
      int base;
      nbytes = (p == 0) ? 4 : 2;
      base   = int'(a) & ~(nbytes - 1);                // Low address bits ignored
      for (int i = 0; i < nbytes; i++)
         ref_mem[base + i] = d[8*i +: 8];
   endtask

   function automatic logic [31:0] ref_read(input int p, input mem_addr_t a);
      int          nbytes;
      int          base;
      logic [31:0] v;
      nbytes = (p == 0) ? 4 : 2;
      base   = int'(a) & ~(nbytes - 1);
      v      = '0;
      for (int i = 0; i < nbytes; i++)
         v[8*i +: 8] = ref_mem[base + i];
      return v;
   endfunction

   // Write updates the model and a read is compared against it
   task automatic apply_op(input int p, input logic we, input mem_addr_t a,
                           input logic [31:0] d, input logic [31:0] rd);
      if (we)
         ref_write(p, a, d);
      else
         check((p == 0) ? "o_p0_rdata" : "o_p1_rdata", rd, ref_read(p, a));
   endtask

   // Strobe one or both ports in the same cycle and follow both to done
   task automatic run_pair(
      input  logic        go0,
      input  logic        we0,
      input  mem_addr_t   a0,
      input  logic [31:0] d0,
      input  logic        go1,
      input  logic        we1,
      input  mem_addr_t   a1,
      input  logic [15:0] d1,
      output logic [31:0] r0,
      output logic [15:0] r1,
      output int          l0,
      output int          l1
   );
      int   n;
      int   first;
      logic seen0;
      logic seen1;
      n  = 0;
      l0 = 0;
      l1 = 0;
      r0 = '0;
      r1 = '0;
      @(negedge clk);
      if ((go0 && o_p0_busy) || (go1 && o_p1_busy))
      begin
         errors++;
         $display("Error at %0t: a strobe was about to go out while its port is busy", $time);
      end
      i_p0_req   = go0;
      i_p0_we    = we0;
      i_p0_addr  = a0;
      i_p0_wdata = d0;
      i_p1_req   = go1;
      i_p1_we    = we1;
      i_p1_addr  = a1;
      i_p1_wdata = d1;
      @(negedge clk);                                  // Sampling edge has passed
      i_p0_req = 1'b0;
      i_p1_req = 1'b0;
      if (go0)
         check("o_p0_busy", o_p0_busy, 1);
      if (go1)
         check("o_p1_busy", o_p1_busy, 1);
      seen0 = !go0;
      seen1 = !go1;
      while (!(seen0 && seen1) && n < 6)
      begin
         @(negedge clk);
         n++;
         if (!seen0 && o_p0_done)
         begin
            seen0 = 1'b1;
            l0    = n;
            r0    = o_p0_rdata;
            check("o_p0_busy", o_p0_busy, 0);
         end
         if (!seen1 && o_p1_done)
         begin
            seen1 = 1'b1;
            l1    = n;
            r1    = o_p1_rdata;
            check("o_p1_busy", o_p1_busy, 0);
         end
      end
      if (!seen0 || !seen1)
      begin
         errors++;
         $display("Error at %0t: an accepted request never completed", $time);
      end
      // Contention goes to the port not served last
      first = go0 ? 0 : 1;
      if (go0 && go1)
         first = (last_served == 1) ? 0 : 1;
      if (go0)
         check("p0 latency", l0, (first == 0) ? 1 : 2);
      if (go1)
         check("p1 latency", l1, (first == 1) ? 1 : 2);
      if (go0 && first == 0)
         apply_op(0, we0, a0, d0, r0);
      if (go1)
         apply_op(1, we1, a1, {16'h0, d1}, {16'h0, r1});
      if (go0 && first == 1)
         apply_op(0, we0, a0, d0, r0);
      last_served = (go0 && go1) ? 1 - first : first;
   endtask

   task automatic test_reset();
      check("o_p0_busy", o_p0_busy, 0);
      check("o_p0_done", o_p0_done, 0);
      check("o_p1_busy", o_p1_busy, 0);
      check("o_p1_done", o_p1_done, 0);
   endtask

   // Known contents for the random window from a pattern of the whole address
   task automatic fill_region();
      for (int a = 0; a < 256; a += 4)
         run_pair(1, 1, a, (32'(a) * 32'h0001_0003) ^ 32'h5ac3_0000, 0, 0, 0, 0,
                  rd0, rd1, lat0, lat1);
   endtask

   task automatic test_round_trip();
      run_pair(1, 1, 12'h040, 32'hdead_beef, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      run_pair(1, 1, 12'h044, 32'h0bad_f00d, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      run_pair(1, 0, 12'h040, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      check("o_p0_rdata", rd0, 32'hdead_beef);
      check("p0 done delay", lat0, 1);                 // One cycle after the sampling edge
      run_pair(1, 0, 12'h044, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      check("o_p0_rdata", rd0, 32'h0bad_f00d);
   endtask

   task automatic test_lanes();
      run_pair(0, 0, 0, 0, 1, 1, 12'h080, 16'ha1b2, rd0, rd1, lat0, lat1);
      run_pair(0, 0, 0, 0, 1, 1, 12'h082, 16'hc3d4, rd0, rd1, lat0, lat1);
      run_pair(0, 0, 0, 0, 1, 1, 12'h084, 16'he5f6, rd0, rd1, lat0, lat1);
      run_pair(0, 0, 0, 0, 1, 1, 12'h086, 16'h0718, rd0, rd1, lat0, lat1);
      run_pair(1, 0, 12'h080, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      check("o_p0_rdata", rd0, 32'hc3d4_a1b2);
      run_pair(1, 0, 12'h084, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      check("o_p0_rdata", rd0, 32'h0718_e5f6);
      run_pair(0, 0, 0, 0, 1, 1, 12'h082, 16'h5566, rd0, rd1, lat0, lat1); // Upper half only
      run_pair(1, 0, 12'h080, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      check("o_p0_rdata", rd0, 32'h5566_a1b2);
      run_pair(1, 0, 12'h084, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1);
      check("o_p0_rdata", rd0, 32'h0718_e5f6);
   endtask

   task automatic test_arbitration();
      run_pair(0, 0, 0, 0, 1, 0, 12'h086, 0, rd0, rd1, lat0, lat1); // Port 1 served last
      check("o_p1_rdata", rd1, 16'h0718);
      run_pair(1, 1, 12'h0c0, 32'h7654_3210, 1, 1, 12'h0ca, 16'h9abc, rd0, rd1, lat0, lat1);
      check("p0 done delay", lat0, 1);
      check("p1 done delay", lat1, 2);
      run_pair(1, 0, 12'h0c4, 0, 0, 0, 0, 0, rd0, rd1, lat0, lat1); // Port 0 served last
      run_pair(1, 0, 12'h0c0, 0, 1, 0, 12'h0ca, 0, rd0, rd1, lat0, lat1);
      check("p0 done delay", lat0, 2);                 // Order flips
      check("p1 done delay", lat1, 1);
      check("o_p0_rdata", rd0, 32'h7654_3210);
      check("o_p1_rdata", rd1, 16'h9abc);
   endtask

   task automatic test_random();
      logic go0;
      logic go1;
      for (int i = 0; i < 200; i++)
      begin
         go0 = ($urandom % 2) == 0;
         go1 = !go0 || (($urandom % 6) == 0);          // Both now and then
         run_pair(go0, $urandom % 2, $urandom % 256, $urandom,
                  go1, $urandom % 2, $urandom % 256, $urandom,
                  rd0, rd1, lat0, lat1);
      end
   endtask

   initial
   begin
      void'($urandom(32'hdd92fea8));
      repeat (10) @(negedge clk);                      // Reset for 10 cycles
      i_rst_n = 1'b1;
      test_reset();
      fill_region();
      test_round_trip();
      test_lanes();
      test_arbitration();
      test_random();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ncpu_mem.f ====
logic/ncpu_mem_pkg.sv
logic/align_w.sv
logic/align_r.sv
logic/mem_port.sv
logic/bus_arbiter.sv
logic/sram_bank.sv
logic/ncpu_mem_top.sv
sim/tb_ncpu_mem_top.sv

// ==== Bender.yml ====
package:
  name: ncpu_mem

sources:
  - logic/ncpu_mem_pkg.sv
  - logic/align_w.sv
  - logic/align_r.sv
  - logic/mem_port.sv
  - logic/bus_arbiter.sv
  - logic/sram_bank.sv
  - logic/ncpu_mem_top.sv
  - target: simulation
    files:
      - sim/tb_ncpu_mem_top.sv
